// File: src.f
source/cpu_pkg.sv
source/instr_decoder.sv
source/instr_issue.sv
source/issue_buffer.sv
source/ex_stage_reg.sv
source/dual_issue_core.sv
sim/issue_checker.sv
sim/issue_assertions.sv
sim/tb_dual_issue.sv

// File: Bender.yml
package:
  name: dual_issue_core

sources:
  - files:
      - source/cpu_pkg.sv
      - source/instr_decoder.sv
      - source/instr_issue.sv
      - source/issue_buffer.sv
      - source/ex_stage_reg.sv
      - source/dual_issue_core.sv
  - target: simulation
    files:
      - sim/issue_checker.sv
      - sim/issue_assertions.sv
      - sim/tb_dual_issue.sv

// File: sim/tb_dual_issue.sv
`default_nettype none
`timescale 1ns/1ps

module tb_dual_issue;

	typedef struct packed {
		logic [31:0] w0;
		logic [31:0] w1;
		logic        v0;
		logic        v1;
		logic        ds;     // delayslot_not_exec level
		logic        chain;  // next row is pushed without draining
		logic        dual;   // expected pair issue when both are valid
	} stim_row_t;

	logic                                             clk;
	logic                                             arst_n;
	logic                                             fetch_push;
	cpu_pkg::fetch_entry_t   [cpu_pkg::ISSUE_NUM-1:0] fetch_pair;
	logic                                             delayslot_not_exec;
	logic                                             buf_full;
	logic                                             buf_empty;
	cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] ex_instr;
	logic                                             exp_pair;
	logic                                             end_of_test;
	int                                               error_count;
	integer                                           seed = 96;
	stim_row_t                                        rows [$];

	dual_issue_core dual_issue_core_i (.*);

	issue_checker issue_checker_i (.*);

	function automatic logic [31:0] rand_alu();
		logic [31:0] r;
		r = $random(seed);
		return {6'h00, r[14:0], 5'h00, 6'h21};  // addu, random rs rt rd
	endfunction

	initial begin : clock
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin : watchdog
		#1;
		#(rows.size() * 20 * 8);
		$display("watchdog expired after %0d cycles without finishing", rows.size() * 20);
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] pc;
		pc = 32'h0000_1000;
		arst_n = 1'b0;
		fetch_push = 1'b0;
		fetch_pair = '0;
		delayslot_not_exec = 1'b0;
		exp_pair = 1'b0;
		end_of_test = 1'b0;

		// w0, w1, {v0, v1, ds, chain, dual}
		rows.push_back({32'h0022_1821, 32'h0085_3021, 5'b11001});  // independent addu pair
		rows.push_back({32'h0022_1821, 32'h0061_3821, 5'b11000});  // slot 1 reads r3
		rows.push_back({32'h8C22_0000, 32'hAC25_0004, 5'b11000});  // lw + sw
		rows.push_back({32'h0022_0018, 32'h0000_5010, 5'b11000});  // mult + mfhi
		rows.push_back({32'h0000_0040, 32'h0085_3021, 5'b11000});  // ssnop first
		rows.push_back({32'h0085_3021, 32'h400B_6000, 5'b11000});  // mfc0 in slot 1
		rows.push_back({32'h4084_6000, 32'h4200_0018, 5'b11000});  // mtc0 then eret
		rows.push_back({32'h8C28_0008, 32'h0022_1821, 5'b11011});  // lw r8, then user
		rows.push_back({32'h0104_4821, 32'h0000_0000, 5'b10000});  // reads r8
		rows.push_back({rand_alu(), rand_alu(), 5'b11100});
		rows.push_back({32'h0022_1821, 32'h0085_3021, 5'b11110});  // three pushes back to back
		rows.push_back({rand_alu(), rand_alu(), 5'b11110});
		rows.push_back({rand_alu(), rand_alu(), 5'b11100});        // meets a full buffer
		rows.push_back({32'h0000_0000, rand_alu(), 5'b01000});     // only slot 1 valid
		rows.push_back({32'h0022_1821, 32'h0085_3021, 5'b11001});

		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		foreach (rows[r]) begin
			@(posedge clk);
			fetch_push <= 1'b1;
			fetch_pair[0] <= {rows[r].v0, pc, rows[r].w0};
			fetch_pair[1] <= {rows[r].v1, pc + 32'd4, rows[r].w1};
			delayslot_not_exec <= rows[r].ds;
			exp_pair <= rows[r].dual;
			pc = pc + 32'd8;
			do
				@(negedge clk);
			while (buf_full);  // fetch holds the pair until there is room
			if (!rows[r].chain) begin
				@(posedge clk);
				fetch_push <= 1'b0;
				do
					@(negedge clk);
				while (!buf_empty || ex_instr[0].valid || ex_instr[1].valid);
			end
		end

		@(posedge clk);
		end_of_test <= 1'b1;
		repeat (2) @(posedge clk);
		$display("error count: checker %0d, assertions %0d", error_count,
			dual_issue_core_i.issue_assertions_i.fail_count);
		if (error_count == 0 && dual_issue_core_i.issue_assertions_i.fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/issue_assertions.sv
`default_nettype none
`timescale 1ns/1ps

module issue_assertions (
	input logic                                             clk,
	input logic                                             arst_n,
	input logic                                             buf_full,
	input logic                                             buf_empty,
	input cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] ex_instr
);

	int fail_count = 0;  // tally of failed assertions

	// an empty buffer stalls issue, so execute sees a bubble next
	empty_gives_bubble: assert property (@(posedge clk) disable iff (!arst_n)
		buf_empty |=> ex_instr == '0)
	else begin
		$error("empty issue buffer let an instruction into execute");
		fail_count++;
	end

	slot_order: assert property (@(posedge clk) disable iff (!arst_n)
		ex_instr[1].valid |-> ex_instr[0].valid)
	else begin
		$error("execute slot 1 holds an instruction while slot 0 is empty");
		fail_count++;
	end

	valid_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({ex_instr[1].valid, ex_instr[0].valid}))
	else begin
		$error("execute valid bits are unknown");
		fail_count++;
	end

endmodule

bind dual_issue_core issue_assertions issue_assertions_i (.*);

`default_nettype wire

// File: sim/issue_checker.sv
`default_nettype none
`timescale 1ns/1ps

module issue_checker (
	input  logic                                             clk,
	input  logic                                             arst_n,
	input  logic                                             fetch_push,
	input  cpu_pkg::fetch_entry_t   [cpu_pkg::ISSUE_NUM-1:0] fetch_pair,
	input  logic                                             delayslot_not_exec,
	input  logic                                             exp_pair,
	input  logic                                             end_of_test,
	input  logic                                             buf_full,
	input  logic                                             buf_empty,
	input  cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] ex_instr,
	output int                                               error_count
);

	cpu_pkg::decoded_instr_t                          pend [$];  // model of the buffer
	cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] ex_model;
	logic [32:0]                                      pair_q [$];  // {dual expected, slot 0 pc}
	logic                                             reported;

	// only the instructions the stimulus uses
	function automatic cpu_pkg::decoded_instr_t model_decode(input cpu_pkg::fetch_entry_t e);
		cpu_pkg::decoded_instr_t d;
		d = '0;
		d.valid = 1'b1;
		d.pc = e.pc;
		d.rs1 = e.instr[25:21];
		d.rs2 = e.instr[20:16];
		d.op = cpu_pkg::OP_ALU;
		case (e.instr[31:26])
			6'h00: begin
				d.rd = e.instr[15:11];
				if (e.instr == 32'h0000_0040)
					d.op = cpu_pkg::OP_SSNOP;
				else if (e.instr[5:0] == 6'h10 || e.instr[5:0] == 6'h12 || e.instr[5:0] == 6'h18)
					d.op = cpu_pkg::OP_HILO;  // mfhi, mflo, mult
			end
			6'h23: begin
				d.op = cpu_pkg::OP_LOAD;
				d.rs2 = '0;
				d.rd = e.instr[20:16];
			end
			6'h2b: d.op = cpu_pkg::OP_STORE;
			6'h10: begin
				d.op = (e.instr == 32'h4200_0018) ? cpu_pkg::OP_ERET : cpu_pkg::OP_PRIV;
				d.rs1 = '0;
				d.rs2 = (e.instr[25:21] == 5'd4) ? e.instr[20:16] : 5'd0;  // mtc0 reads rt
				d.rd = (e.instr[25:21] == 5'd0) ? e.instr[20:16] : 5'd0;   // mfc0 writes rt
			end
			default: begin
				d.rs2 = '0;
				d.rd = e.instr[20:16];
			end
		endcase
		return e.valid ? d : '0;
	endfunction

	function automatic logic reads(input cpu_pkg::decoded_instr_t d, input cpu_pkg::reg_addr_t r);
		return r != '0 && (d.rs1 == r || d.rs2 == r);
	endfunction

	function automatic logic is_priv(input cpu_pkg::decoded_instr_t d);
		return d.op == cpu_pkg::OP_PRIV || d.op == cpu_pkg::OP_ERET;
	endfunction

	function automatic logic is_mem(input cpu_pkg::decoded_instr_t d);
		return d.op == cpu_pkg::OP_LOAD || d.op == cpu_pkg::OP_STORE;
	endfunction

	// fetch needs two free slots for a whole pair
	function automatic logic no_room(input int occupied);
		return cpu_pkg::BUF_DEPTH - occupied < 2;
	endfunction

	function automatic logic load_use(input cpu_pkg::decoded_instr_t d,
			input cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] ex);
		return (ex[0].op == cpu_pkg::OP_LOAD && reads(d, ex[0].rd))
			|| (ex[1].op == cpu_pkg::OP_LOAD && reads(d, ex[1].rd));
	endfunction

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	// compare what the last edge produced, then step the model to the coming edge
	always @(negedge clk) begin : step
		cpu_pkg::decoded_instr_t h0;
		cpu_pkg::decoded_instr_t h1;
		logic                    drop;
		logic                    stall;
		logic                    accept;
		logic                    dual;
		if (!arst_n) begin
			pend.delete();
			pair_q.delete();
			ex_model = '0;
			error_count = 0;
			reported = 1'b0;
		end else begin
			for (int i = 0; i < cpu_pkg::ISSUE_NUM; i++) begin
				compare_field($sformatf("ex_instr[%0d].valid", i), ex_instr[i].valid,
					ex_model[i].valid);
				compare_field($sformatf("ex_instr[%0d].pc", i), ex_instr[i].pc, ex_model[i].pc);
				compare_field($sformatf("ex_instr[%0d].op", i), ex_instr[i].op, ex_model[i].op);
			end
			compare_field("buf_full", buf_full, no_room(pend.size()));
			compare_field("buf_empty", buf_empty, pend.size() == 0);
			if (ex_instr[0].valid && pair_q.size() > 0 && ex_instr[0].pc == pair_q[0][31:0]) begin
				dual = ex_instr[1].valid && ex_instr[1].pc == ex_instr[0].pc + 32'd4;
				compare_field("dual issue", dual, pair_q[0][32]);
				void'(pair_q.pop_front());
			end
			if (end_of_test && !reported) begin
				if (pend.size() != 0 || pair_q.size() != 0) begin
					$display("%0d pushed instructions never reached execute, %0d pair checks unseen",
						pend.size(), pair_q.size());
					error_count++;
				end
				reported = 1'b1;
			end

			h0 = (pend.size() > 0) ? pend[0] : '0;
			h1 = (pend.size() > 1) ? pend[1] : '0;
			accept = fetch_push && !no_room(pend.size());
			drop = !h1.valid || reads(h1, h0.rd) || (is_mem(h0) && is_mem(h1))
				|| (h0.op == cpu_pkg::OP_HILO && h1.op == cpu_pkg::OP_HILO)
				|| delayslot_not_exec || h0.op == cpu_pkg::OP_SSNOP
				|| h1.op == cpu_pkg::OP_SSNOP || is_priv(h0) || is_priv(h1);
			stall = !h0.valid || load_use(h0, ex_model) || (!drop && load_use(h1, ex_model))
				|| (h0.op == cpu_pkg::OP_ERET && (is_priv(ex_model[0]) || is_priv(ex_model[1])));
			if (stall) begin
				ex_model = '0;
			end else begin
				ex_model[0] = h0;
				ex_model[1] = drop ? '0 : h1;
				void'(pend.pop_front());
				if (!drop)
					void'(pend.pop_front());
			end
			if (accept) begin
				if (fetch_pair[0].valid)
					pend.push_back(model_decode(fetch_pair[0]));
				if (fetch_pair[1].valid)
					pend.push_back(model_decode(fetch_pair[1]));
				if (fetch_pair[0].valid && fetch_pair[1].valid)
					pair_q.push_back({exp_pair, fetch_pair[0].pc});
			end
		end
	end

endmodule

`default_nettype wire

// File: source/dual_issue_core.sv
`default_nettype none
`timescale 1ns/1ps

module dual_issue_core (
	input  logic                                             clk,
	input  logic                                             arst_n,
	input  logic                                             fetch_push,
	input  cpu_pkg::fetch_entry_t   [cpu_pkg::ISSUE_NUM-1:0] fetch_pair,
	input  logic                                             delayslot_not_exec,
	output logic                                             buf_full,
	output logic                                             buf_empty,
	output cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] ex_instr
);

	cpu_pkg::fetch_entry_t   [cpu_pkg::ISSUE_NUM-1:0] head_entries;
	cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] id_decoded;
	cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] issue_instr;
	cpu_pkg::issue_count_t                            issue_num;
	logic                                             stall_req;

	issue_buffer issue_buffer_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.push         (fetch_push),
		.push_pair    (fetch_pair),
		.pop_num      (issue_num),
		.stall        (stall_req),
		.head_entries (head_entries),
		.full         (buf_full),
		.empty        (buf_empty)
	);

	for (genvar i = 0; i < cpu_pkg::ISSUE_NUM; i++) begin : gen_dec
		instr_decoder instr_decoder_i (
			.instr   (head_entries[i]),
			.decoded (id_decoded[i])
		);
	end

	// ex_instr loops back so hazards see what really entered execute
	instr_issue instr_issue_i (
		.fetch_entry        (head_entries),
		.id_decoded         (id_decoded),
		.ex_decoded         (ex_instr),
		.delayslot_not_exec (delayslot_not_exec),
		.issue_instr        (issue_instr),
		.issue_num          (issue_num),
		.stall_req          (stall_req)
	);

	ex_stage_reg ex_stage_reg_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.stall       (stall_req),
		.issue_instr (issue_instr),
		.ex_instr    (ex_instr)
	);

endmodule

`default_nettype wire

// File: source/ex_stage_reg.sv
`default_nettype none
`timescale 1ns/1ps

module ex_stage_reg (
	input  logic                                             clk,
	input  logic                                             arst_n,
	input  logic                                             stall,
	input  cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] issue_instr,
	output cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] ex_instr
);

	// a stalled cycle enters execute as an all-zero bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ex_instr <= '0;
		else if (stall)
			ex_instr <= '0;
		else
			ex_instr <= issue_instr;
	end

endmodule

`default_nettype wire

// File: source/issue_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module issue_buffer (
	input  logic                                           clk,
	input  logic                                           arst_n,
	input  logic                                           push,
	input  cpu_pkg::fetch_entry_t [cpu_pkg::ISSUE_NUM-1:0] push_pair,
	input  cpu_pkg::issue_count_t                          pop_num,
	input  logic                                           stall,
	output cpu_pkg::fetch_entry_t [cpu_pkg::ISSUE_NUM-1:0] head_entries,
	output logic                                           full,
	output logic                                           empty
);

	cpu_pkg::fetch_entry_t                     mem [cpu_pkg::BUF_DEPTH];
	logic [$clog2(cpu_pkg::BUF_DEPTH)-1:0]     rd_ptr;
	logic [$clog2(cpu_pkg::BUF_DEPTH)-1:0]     wr_ptr;
	logic [$clog2(cpu_pkg::BUF_DEPTH)-1:0]     wr_ptr_nxt;
	logic [$clog2(cpu_pkg::BUF_DEPTH+1)-1:0]   count;
	cpu_pkg::fetch_entry_t                     wr_first;
	cpu_pkg::issue_count_t                     push_cnt;
	cpu_pkg::issue_count_t                     pop_cnt;
	logic                                      accept;

	assign accept     = push && !full;  // a push while full is lost
	assign wr_ptr_nxt = wr_ptr + 1'b1;

	// squeeze out an invalid slot 0 so the ring stays in program order
	assign wr_first = push_pair[0].valid ? push_pair[0] : push_pair[1];
	assign push_cnt = accept ? 2'(push_pair[0].valid) + 2'(push_pair[1].valid) : 2'd0;
	assign pop_cnt  = stall ? 2'd0 : pop_num;

	always_ff @(posedge clk) begin
		if (push_cnt != '0)
			mem[wr_ptr] <= wr_first;
		if (push_cnt == 2'd2)
			mem[wr_ptr_nxt] <= push_pair[1];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + push_cnt;
			rd_ptr <= rd_ptr + pop_cnt;
			count  <= count + push_cnt - pop_cnt;
		end
	end

	for (genvar i = 0; i < cpu_pkg::ISSUE_NUM; i++) begin : gen_head
		logic [$clog2(cpu_pkg::BUF_DEPTH)-1:0] idx;

		assign idx             = rd_ptr + 2'(i);  // wraps around the ring
		assign head_entries[i] = (count > i) ? mem[idx] : '0;
	end

	// room for a whole pair is needed before fetch may push again
	assign full  = count > cpu_pkg::BUF_DEPTH - cpu_pkg::ISSUE_NUM;
	assign empty = count == '0;

endmodule

`default_nettype wire

// File: source/instr_issue.sv
`default_nettype none
`timescale 1ns/1ps

// two slots only, the drop rules below compare slot 0 against slot 1
module instr_issue (
	input  cpu_pkg::fetch_entry_t   [cpu_pkg::ISSUE_NUM-1:0] fetch_entry,
	input  cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] id_decoded,
	input  cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] ex_decoded,
	input  logic                                             delayslot_not_exec,
	output cpu_pkg::decoded_instr_t [cpu_pkg::ISSUE_NUM-1:0] issue_instr,
	output cpu_pkg::issue_count_t                            issue_num,
	output logic                                             stall_req
);

	logic [cpu_pkg::ISSUE_NUM-1:0] id_valid;
	logic [cpu_pkg::ISSUE_NUM-1:0] load_use;
	logic [cpu_pkg::ISSUE_NUM-1:0] mem_access;
	logic [cpu_pkg::ISSUE_NUM-1:0] hilo_access;
	logic [cpu_pkg::ISSUE_NUM-1:0] ssnop;
	logic [cpu_pkg::ISSUE_NUM-1:0] priv;
	logic [cpu_pkg::ISSUE_NUM-1:0] ex_priv;
	logic                          slot1_drop;
	logic                          eret_wait;

	function automatic logic load_hazard(
		input cpu_pkg::decoded_instr_t id,
		input cpu_pkg::decoded_instr_t ex
	);
		return ex.is_load && ex.rd != '0 && (id.rs1 == ex.rd || id.rs2 == ex.rd);
	endfunction

	// consumer reads what producer writes in the same pair
	function automatic logic raw_dep(
		input cpu_pkg::decoded_instr_t producer,
		input cpu_pkg::decoded_instr_t consumer
	);
		return producer.rd != '0
			&& (consumer.rs1 == producer.rd || consumer.rs2 == producer.rd);
	endfunction

	for (genvar i = 0; i < cpu_pkg::ISSUE_NUM; i++) begin : gen_slot
		assign id_valid[i]    = fetch_entry[i].valid;
		assign mem_access[i]  = id_decoded[i].is_load | id_decoded[i].is_store;
		assign hilo_access[i] = id_decoded[i].is_hilo;
		assign ssnop[i]       = id_decoded[i].is_ssnop;
		assign priv[i]        = id_decoded[i].is_priv;
		assign ex_priv[i]     = ex_decoded[i].is_priv;
	end

	always_comb begin
		load_use = '0;
		for (int i = 0; i < cpu_pkg::ISSUE_NUM; i++) begin
			for (int j = 0; j < cpu_pkg::ISSUE_NUM; j++)
				load_use[i] |= load_hazard(id_decoded[i], ex_decoded[j]);
		end
		load_use &= id_valid;  // invalid slots carry no hazard
	end

	assign slot1_drop = !id_valid[1]
		|| raw_dep(id_decoded[0], id_decoded[1])
		|| &mem_access
		|| &hilo_access
		|| delayslot_not_exec   // mispredicted branch, delay slot still pending
		|| |ssnop
		|| |priv;

	assign eret_wait = id_decoded[0].op == cpu_pkg::OP_ERET && |ex_priv;

	assign stall_req = load_use[0]
		| eret_wait
		| (load_use[1] & ~slot1_drop)
		| (id_valid == '0);

	always_comb begin
		issue_instr = id_decoded;
		issue_num   = 2'd2;
		if (slot1_drop) begin
			issue_instr[1] = '0;
			issue_num      = 2'd1;
		end
	end

endmodule

`default_nettype wire

// File: source/instr_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module instr_decoder (
	input  cpu_pkg::fetch_entry_t   instr,
	output cpu_pkg::decoded_instr_t decoded
);

	cpu_pkg::instr_word_u word;
	logic                 is_cop0;
	logic                 is_load;
	logic                 is_store;
	logic                 is_hilo;
	logic                 is_eret;

	assign word     = instr.instr;
	assign is_cop0  = word.i.opcode == cpu_pkg::OPC_COP0;
	assign is_load  = word.i.opcode[5:3] == cpu_pkg::OPC_LOAD_GRP;
	assign is_store = word.i.opcode[5:3] == cpu_pkg::OPC_STORE_GRP;
	assign is_eret  = is_cop0 && word.raw[25] && word.r.funct == cpu_pkg::FUNCT_ERET;

	// mfhi/mthi/mflo/mtlo/mult/div, then madd/msub and unsigned forms
	assign is_hilo =
		(word.r.opcode == cpu_pkg::OPC_SPECIAL && word.r.funct[5:4] == 2'b01
			&& !word.r.funct[2])
		|| (word.r.opcode == cpu_pkg::OPC_SPECIAL2 && word.r.funct[5:3] == 3'b000
			&& !word.r.funct[1]);

	always_comb begin
		decoded = '0;
		if (instr.valid) begin
			decoded.valid = 1'b1;
			decoded.pc    = instr.pc;

			// register fields depend on the format
			if (word.r.opcode == cpu_pkg::OPC_SPECIAL
					|| word.r.opcode == cpu_pkg::OPC_SPECIAL2) begin
				decoded.rs1 = word.r.rs;
				decoded.rs2 = word.r.rt;
				decoded.rd  = word.r.rd;
			end else if (is_cop0) begin
				if (word.r.rs == cpu_pkg::COP0_MF)
					decoded.rd = word.r.rt;  // mfc0 writes rt
				else if (word.r.rs == cpu_pkg::COP0_MT)
					decoded.rs2 = word.r.rt;
			end else if (is_load || word.i.opcode[5:3] == cpu_pkg::OPC_IMM_GRP) begin
				decoded.rs1 = word.i.rs;
				decoded.rd  = word.i.rt;
			end else begin
				// stores and branches read both, write none
				decoded.rs1 = word.i.rs;
				decoded.rs2 = word.i.rt;
			end

			decoded.is_load  = is_load;
			decoded.is_store = is_store;
			decoded.is_hilo  = is_hilo;
			decoded.is_priv  = is_cop0;
			decoded.is_ssnop = word.raw == cpu_pkg::SSNOP_WORD;

			if (word.raw == '0)
				decoded.op = cpu_pkg::OP_NOP;
			else if (decoded.is_ssnop)
				decoded.op = cpu_pkg::OP_SSNOP;
			else if (is_eret)
				decoded.op = cpu_pkg::OP_ERET;
			else if (is_cop0)
				decoded.op = cpu_pkg::OP_PRIV;
			else if (is_load)
				decoded.op = cpu_pkg::OP_LOAD;
			else if (is_store)
				decoded.op = cpu_pkg::OP_STORE;
			else if (is_hilo)
				decoded.op = cpu_pkg::OP_HILO;
			else
				decoded.op = cpu_pkg::OP_ALU;
		end
	end

endmodule

`default_nettype wire

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int ISSUE_NUM = 2;
	localparam int BUF_DEPTH = 4;

	// primary opcodes and fields the decoder cares about
	localparam logic [5:0]  OPC_SPECIAL  = 6'b000000;
	localparam logic [5:0]  OPC_SPECIAL2 = 6'b011100;
	localparam logic [5:0]  OPC_COP0     = 6'b010000;
	localparam logic [2:0]  OPC_IMM_GRP   = 3'b001;  // addi .. lui
	localparam logic [2:0]  OPC_LOAD_GRP  = 3'b100;  // lb .. lwr
	localparam logic [2:0]  OPC_STORE_GRP = 3'b101;  // sb .. swr
	localparam logic [4:0]  COP0_MF      = 5'b00000;
	localparam logic [4:0]  COP0_MT      = 5'b00100;
	localparam logic [5:0]  FUNCT_ERET   = 6'b011000;
	localparam logic [31:0] SSNOP_WORD   = 32'h0000_0040;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	// zero is the bubble encoding
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ALU,
		OP_LOAD,
		OP_STORE,
		OP_HILO,
		OP_SSNOP,
		OP_PRIV,
		OP_ERET
	} op_t;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t  r;
		i_fmt_t  i;
		uint32_t raw;
	} instr_word_u;

	typedef struct packed {
		logic    valid;
		uint32_t pc;
		uint32_t instr;
	} fetch_entry_t;

	typedef struct packed {
		logic      valid;
		uint32_t   pc;
		op_t       op;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;  // zero when nothing is written
		logic      is_load;
		logic      is_store;
		logic      is_priv;
		logic      is_hilo;
		logic      is_ssnop;
	} decoded_instr_t;

	typedef logic [$clog2(ISSUE_NUM+1)-1:0] issue_count_t;

endpackage

`default_nettype wire
